// ==== files.f ====
+incdir+source
source/spin_pkg.sv
source/energy_pkg.sv
source/energy_fifo_maintainer.sv
source/spin_fifo_maintainer.sv
source/flip_engine.sv
source/flip_manager.sv
dv/flip_manager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the flip manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module flip_manager_tb \
    --Mdir obj_dir -o flip_manager_tb_sim > build.log 2>&1 \
    && ./obj_dir/flip_manager_tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat build.log; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0

// ==== dv/flip_manager_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flip_defs.svh"

module flip_manager_tb
    import energy_pkg::*;
();
    localparam int WAIT_LIMIT = 300;

    logic clk_i;
    logic reset_i;
    logic en_i;
    logic flush_i;
    logic cmpt_en_i;
    logic cmpt_idle_o;
    logic host_readout_i;
    logic spin_configure_valid_i;
    logic [`FLIP_DATASPIN-1:0] spin_configure_i;
    logic spin_configure_push_none_i;
    logic spin_configure_ready_o;
    logic spin_pop_valid_o;
    logic [`FLIP_DATASPIN-1:0] spin_pop_o;
    logic spin_pop_ready_i = 1'b1;
    logic spin_valid_i;
    logic [`FLIP_DATASPIN-1:0] spin_i;
    logic spin_ready_o;
    logic energy_valid_i;
    logic energy_ready_o;
    energy_t energy_i;
    logic flip_ren_o;
    logic [`FLIP_ICON_ADDR_W-1:0] flip_raddr_o;
    logic [`FLIP_DATASPIN-1:0] flip_rdata_i = '0;
    logic debug_cmpt_stop_i;
    logic flip_disable_i;

    // Scoreboard state
    logic [`FLIP_DATASPIN-1:0] exp_q[$];
    logic [`FLIP_DATASPIN-1:0] pend_q[$];
    logic [`FLIP_DATASPIN-1:0] anchor;
    logic [`FLIP_DATASPIN-1:0] exp_head;
    logic [`FLIP_DATASPIN-1:0] exp_out;
    logic [`FLIP_ICON_ADDR_W-1:0] icon_idx;
    logic exp_have;
    logic pend_have;
    energy_t best_e;
    int check_errors = 0;
    int run_errors = 0;
    logic stall_on = 1'b0;
    int hold_left = 0;

    flip_manager DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Icon memory, one-hot pattern per address, registered read
    always @(posedge clk_i) begin
        if (flip_ren_o) begin
            flip_rdata_i <= {{(`FLIP_DATASPIN-1){1'b0}}, 1'b1} << flip_raddr_o;
        end
    end

    // Output sink with random stall runs
    always @(negedge clk_i) begin
        if (!stall_on) begin
            spin_pop_ready_i = 1'b1;
        end else if (hold_left == 0) begin
            spin_pop_ready_i = ($urandom_range(0, 1) == 1);
            hold_left = $urandom_range(1, 5);
        end else begin
            hold_left--;
        end
    end

    // Reference model of the push and pop streams
    always @(posedge clk_i) begin
        logic [`FLIP_DATASPIN-1:0] stored;
        if (reset_i) begin
            exp_q.delete();
            pend_q.delete();
            icon_idx = '0;
            best_e = 16'sh7fff;
        end else if (en_i) begin
            if (cmpt_en_i) begin
                best_e = 16'sh7fff;
                icon_idx = '0;
            end
            if (spin_configure_valid_i && spin_configure_ready_o) begin
                stored = spin_configure_push_none_i ? anchor : spin_configure_i;
                if (!spin_configure_push_none_i) begin
                    anchor = spin_configure_i;
                end
                exp_q.push_back(stored);
            end
            if (spin_valid_i && spin_ready_o) begin
                pend_q.push_back(spin_i);
            end
            // Strictly lower energy moves the anchor
            if (energy_valid_i && energy_ready_o) begin
                stored = pend_q.pop_front();
                if (energy_i < best_e) begin
                    best_e = energy_i;
                    anchor = stored;
                end else begin
                    stored = anchor;
                end
                exp_q.push_back(stored);
            end
            if (spin_pop_valid_o && spin_pop_ready_i) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                icon_idx = icon_idx + 1'b1;
            end
        end
        exp_have = (exp_q.size() != 0);
        exp_head = exp_have ? exp_q[0] : '0;
        pend_have = (pend_q.size() != 0);
    end

    assign exp_out = exp_head ^ (flip_disable_i ? '0 :
                     ({{(`FLIP_DATASPIN-1){1'b0}}, 1'b1} << icon_idx));

    reset_state_check: assert property (@(posedge clk_i)
        $fell(reset_i) |-> (cmpt_idle_o && !spin_pop_valid_o && !flip_ren_o))
        else begin
            $display("[FAIL] %0t cmpt_idle_o/spin_pop_valid_o/flip_ren_o got %b%b%b expected 100",
                     $time, $sampled(cmpt_idle_o), $sampled(spin_pop_valid_o),
                     $sampled(flip_ren_o));
            check_errors++;
        end

    out_present_check: assert property (@(posedge clk_i) disable iff (reset_i)
        (spin_pop_valid_o && spin_pop_ready_i) |-> exp_have)
        else begin
            $display("An output appeared with no predicted vector left at %0t", $time);
            check_errors++;
        end

    out_value_check: assert property (@(posedge clk_i) disable iff (reset_i)
        (spin_pop_valid_o && spin_pop_ready_i && exp_have) |-> (spin_pop_o == exp_out))
        else begin
            $display("[FAIL] %0t spin_pop_o got %h expected %h", $time,
                     $sampled(spin_pop_o), $sampled(exp_out));
            check_errors++;
        end

    // Stalled output must stay put
    stall_hold_check: assert property (@(posedge clk_i) disable iff (reset_i)
        (spin_pop_valid_o && !spin_pop_ready_i) |=> (spin_pop_valid_o && $stable(spin_pop_o)))
        else begin
            $display("Output vanished or changed while stalled at %0t", $time);
            check_errors++;
        end

    config_block_check: assert property (@(posedge clk_i) disable iff (reset_i)
        !cmpt_idle_o |-> !spin_configure_ready_o)
        else begin
            $display("[FAIL] %0t spin_configure_ready_o got 1 expected 0", $time);
            check_errors++;
        end

    // Energy is taken only when a spin is waiting for it
    energy_gate_check: assert property (@(posedge clk_i) disable iff (reset_i)
        energy_ready_o |-> pend_have)
        else begin
            $display("[FAIL] %0t energy_ready_o got 1 expected 0", $time);
            check_errors++;
        end

    start_check: assert property (@(posedge clk_i) disable iff (reset_i)
        (cmpt_en_i && cmpt_idle_o) |=> !cmpt_idle_o)
        else begin
            $display("[FAIL] %0t cmpt_idle_o got 1 expected 0", $time);
            check_errors++;
        end

    task automatic send_config(input logic [`FLIP_DATASPIN-1:0] value);
        int waited;
        waited = 0;
        @(negedge clk_i);
        spin_configure_valid_i = 1'b1;
        spin_configure_i = value;
        @(posedge clk_i);
        while (!spin_configure_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!spin_configure_ready_o) begin
            $display("Timeout: configuration push was never accepted");
            run_errors++;
        end
        @(negedge clk_i);
        spin_configure_valid_i = 1'b0;
    endtask

    task automatic send_spin(input logic [`FLIP_DATASPIN-1:0] value);
        int waited;
        waited = 0;
        @(negedge clk_i);
        spin_valid_i = 1'b1;
        spin_i = value;
        @(posedge clk_i);
        while (!spin_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!spin_ready_o) begin
            $display("Timeout: evaluated spin was never accepted");
            run_errors++;
        end
        @(negedge clk_i);
        spin_valid_i = 1'b0;
    endtask

    task automatic send_energy(input energy_t value);
        int waited;
        waited = 0;
        @(negedge clk_i);
        energy_valid_i = 1'b1;
        energy_i = value;
        @(posedge clk_i);
        while (!energy_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!energy_ready_o) begin
            $display("Timeout: energy was never accepted");
            run_errors++;
        end
        @(negedge clk_i);
        energy_valid_i = 1'b0;
    endtask

    // Random spin with an energy around zero, so both outcomes occur
    task automatic send_pair();
        int r;
        r = int'($urandom_range(0, 2000)) - 1000;
        send_spin(`FLIP_DATASPIN'($urandom));
        send_energy(energy_t'(r));
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d predicted outputs never appeared", exp_q.size());
            run_errors++;
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!cmpt_idle_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!cmpt_idle_o) begin
            $display("Timeout: computation did not return to idle");
            run_errors++;
        end
    endtask

    task automatic pulse_start();
        @(negedge clk_i);
        cmpt_en_i = 1'b1;
        @(negedge clk_i);
        cmpt_en_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h03e4_7036));
        reset_i = 1'b1;
        en_i = 1'b1;
        flush_i = 1'b0;
        cmpt_en_i = 1'b0;
        host_readout_i = 1'b0;
        spin_configure_valid_i = 1'b0;
        spin_configure_i = '0;
        spin_configure_push_none_i = 1'b0;
        spin_valid_i = 1'b0;
        spin_i = '0;
        energy_valid_i = 1'b0;
        energy_i = '0;
        debug_cmpt_stop_i = 1'b0;
        flip_disable_i = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // Host load then readout, flipped and then plain
        for (int pass = 0; pass < 2; pass++) begin
            @(negedge clk_i);
            flip_disable_i = (pass == 1);
            for (int i = 0; i < 3; i++) begin
                send_config(`FLIP_DATASPIN'($urandom));
            end
            @(negedge clk_i);
            host_readout_i = 1'b1;
            wait_drained();
            host_readout_i = 1'b0;
        end
        @(negedge clk_i);
        flip_disable_i = 1'b0;

        // Full run ended by icon finish, under back-pressure
        stall_on = 1'b1;
        pulse_start();
        for (int i = 0; i < `FLIP_ICON_DEPTH; i++) begin
            send_pair();
        end
        wait_idle();

        // Short run ended by the debug stop
        pulse_start();
        for (int i = 0; i < 3; i++) begin
            send_pair();
        end
        wait_drained();
        @(negedge clk_i);
        debug_cmpt_stop_i = 1'b1;
        @(negedge clk_i);
        debug_cmpt_stop_i = 1'b0;
        wait_idle();

        stall_on = 1'b0;
        repeat (5) @(negedge clk_i);
        assert (exp_q.size() == 0)
        else begin
            $display("%0d predicted outputs were lost", exp_q.size());
            run_errors++;
        end
        $display("Closing report: %0d assertion errors, %0d run errors",
                 check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/flip_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flip_defs.svh"

module flip_manager
    import energy_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         en_i,
    input  logic                         flush_i,
    input  logic                         cmpt_en_i,
    output logic                         cmpt_idle_o,
    input  logic                         host_readout_i,
    input  logic                         spin_configure_valid_i,
    input  logic [`FLIP_DATASPIN-1:0]    spin_configure_i,
    input  logic                         spin_configure_push_none_i,
    output logic                         spin_configure_ready_o,
    output logic                         spin_pop_valid_o,
    output logic [`FLIP_DATASPIN-1:0]    spin_pop_o,
    input  logic                         spin_pop_ready_i,
    input  logic                         spin_valid_i,
    input  logic [`FLIP_DATASPIN-1:0]    spin_i,
    output logic                         spin_ready_o,
    input  logic                         energy_valid_i,
    output logic                         energy_ready_o,
    input  energy_t                      energy_i,
    output logic                         flip_ren_o,
    output logic [`FLIP_ICON_ADDR_W-1:0] flip_raddr_o,
    input  logic [`FLIP_DATASPIN-1:0]    flip_rdata_i,
    input  logic                         debug_cmpt_stop_i,
    input  logic                         flip_disable_i
);
    logic                      cmpt_busy;
    logic                      cmpt_stop;
    logic                      icon_finish;
    logic                      engine_empty;
    // Push stream into the spin FIFO after the mux
    logic                      push_valid;
    logic [`FLIP_DATASPIN-1:0] push_spin;
    logic                      push_none;
    logic                      push_ready;
    // Push stream from the energy side
    logic                      en_push_valid;
    logic [`FLIP_DATASPIN-1:0] en_push_spin;
    logic                      en_push_none;
    // Pop stream into the flip engine
    logic                      pop_valid;
    logic [`FLIP_DATASPIN-1:0] pop_spin;
    logic                      pop_ready;

    assign cmpt_idle_o = ~cmpt_busy;
    assign cmpt_stop = debug_cmpt_stop_i | icon_finish;

    // Host configures only while idle, energy side owns the FIFO when busy
    assign spin_configure_ready_o = push_ready & cmpt_idle_o;
    assign push_valid = cmpt_busy ? en_push_valid : spin_configure_valid_i;
    assign push_spin = cmpt_busy ? en_push_spin : spin_configure_i;
    assign push_none = cmpt_busy ? en_push_none : spin_configure_push_none_i;

    energy_fifo_maintainer u_energy_fifo_maintainer (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .en_i             (en_i),
        .flush_i          (flush_i),
        .cmpt_start_i     (cmpt_en_i),
        .spin_valid_i     (spin_valid_i),
        .spin_i           (spin_i),
        .spin_ready_o     (spin_ready_o),
        .energy_valid_i   (energy_valid_i),
        .energy_i         (energy_i),
        .energy_ready_o   (energy_ready_o),
        .spin_valid_o     (en_push_valid),
        .spin_o           (en_push_spin),
        .spin_push_none_o (en_push_none),
        .spin_ready_i     (push_ready & cmpt_busy)
    );

    spin_fifo_maintainer u_spin_fifo_maintainer (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .en_i              (en_i),
        .flush_i           (flush_i),
        .cmpt_en_i         (cmpt_en_i),
        .cmpt_stop_i       (cmpt_stop),
        .host_readout_i    (host_readout_i),
        .spin_push_valid_i (push_valid),
        .spin_push_i       (push_spin),
        .spin_push_none_i  (push_none),
        .spin_push_ready_o (push_ready),
        .spin_pop_valid_o  (pop_valid),
        .spin_pop_o        (pop_spin),
        .spin_pop_ready_i  (pop_ready),
        .engine_empty_i    (engine_empty),
        .cmpt_busy_o       (cmpt_busy)
    );

    flip_engine u_flip_engine (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .en_i                 (en_i),
        .flush_i              (flush_i),
        .cmpt_en_i            (cmpt_en_i),
        .flip_disable_i       (flip_disable_i),
        .prev_spin_valid_i    (pop_valid),
        .prev_spin_i          (pop_spin),
        .prev_spin_ready_o    (pop_ready),
        .flipped_spin_valid_o (spin_pop_valid_o),
        .flipped_spin_o       (spin_pop_o),
        .flipped_spin_ready_i (spin_pop_ready_i),
        .flip_ren_o           (flip_ren_o),
        .flip_raddr_o         (flip_raddr_o),
        .flip_rdata_i         (flip_rdata_i),
        .icon_finish_o        (icon_finish),
        .empty_o              (engine_empty)
    );

endmodule

`default_nettype wire

// ==== source/flip_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flip_defs.svh"

module flip_engine
    import spin_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         en_i,
    input  logic                         flush_i,
    input  logic                         cmpt_en_i,
    input  logic                         flip_disable_i,
    input  logic                         prev_spin_valid_i,
    input  logic [`FLIP_DATASPIN-1:0]    prev_spin_i,
    output logic                         prev_spin_ready_o,
    output logic                         flipped_spin_valid_o,
    output logic [`FLIP_DATASPIN-1:0]    flipped_spin_o,
    input  logic                         flipped_spin_ready_i,
    output logic                         flip_ren_o,
    output logic [`FLIP_ICON_ADDR_W-1:0] flip_raddr_o,
    input  logic [`FLIP_DATASPIN-1:0]    flip_rdata_i,
    output logic                         icon_finish_o,
    output logic                         empty_o
);
    // READ slot waits for the icon, HOLD slot drives the output
    flip_stage_e                  rd_stage_q;
    flip_stage_e                  hold_stage_q;
    logic [`FLIP_DATASPIN-1:0]    rd_spin_q;
    logic                         rd_nf_q;
    logic [`FLIP_DATASPIN-1:0]    hold_spin_q;
    logic [`FLIP_ICON_ADDR_W-1:0] addr_q;
    logic                         alive_q;
    logic                         run_ok;
    logic                         accept;
    logic                         rd_move;
    logic                         hold_take;

    assign run_ok = alive_q & en_i & ~flush_i;

    assign flipped_spin_valid_o = en_i & (hold_stage_q == HOLD);
    assign flipped_spin_o = hold_spin_q;
    assign hold_take = flipped_spin_valid_o & flipped_spin_ready_i;

    // READ advances only into a free or emptying HOLD slot
    assign rd_move = en_i & (rd_stage_q == READ) & ((hold_stage_q == EMPTY) | hold_take);
    assign prev_spin_ready_o = run_ok & ((rd_stage_q == EMPTY) | rd_move);
    assign accept = prev_spin_valid_i & prev_spin_ready_o;

    // Icon read issues in the cycle of acceptance
    assign flip_ren_o = accept;
    assign flip_raddr_o = addr_q;
    assign icon_finish_o = accept & (int'(addr_q) == `FLIP_ICON_DEPTH - 1);
    assign empty_o = (rd_stage_q == EMPTY) & (hold_stage_q == EMPTY);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alive_q      <= 1'b0;
            rd_stage_q   <= EMPTY;
            hold_stage_q <= EMPTY;
            addr_q       <= '0;
        end else begin
            alive_q <= 1'b1;
            if (en_i) begin
                // Running icon address, wraps after the last icon
                if (cmpt_en_i) begin
                    addr_q <= '0;
                end else if (accept) begin
                    addr_q <= icon_finish_o ? '0 : addr_q + 1'b1;
                end
                if (flush_i) begin
                    rd_stage_q   <= EMPTY;
                    hold_stage_q <= EMPTY;
                end else begin
                    if (accept) begin
                        rd_stage_q <= READ;
                    end else if (rd_move) begin
                        rd_stage_q <= EMPTY;
                    end
                    if (rd_move) begin
                        hold_stage_q <= HOLD;
                    end else if (hold_take) begin
                        hold_stage_q <= EMPTY;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_spin_q <= prev_spin_i;
            rd_nf_q   <= flip_disable_i;
        end
        // Icon data is valid while the vector sits in READ
        if (rd_move) begin
            hold_spin_q <= rd_nf_q ? rd_spin_q : (rd_spin_q ^ flip_rdata_i);
        end
    end

    // Stalled output keeps its data
    assert property (@(posedge clk_i) disable iff (reset_i)
        (flipped_spin_valid_o && !flipped_spin_ready_i) |=> $stable(flipped_spin_o));

endmodule

`default_nettype wire

// ==== source/spin_fifo_maintainer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flip_defs.svh"

module spin_fifo_maintainer
    import spin_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      en_i,
    input  logic                      flush_i,
    input  logic                      cmpt_en_i,
    input  logic                      cmpt_stop_i,
    input  logic                      host_readout_i,
    input  logic                      spin_push_valid_i,
    input  logic [`FLIP_DATASPIN-1:0] spin_push_i,
    input  logic                      spin_push_none_i,
    output logic                      spin_push_ready_o,
    output logic                      spin_pop_valid_o,
    output logic [`FLIP_DATASPIN-1:0] spin_pop_o,
    input  logic                      spin_pop_ready_i,
    input  logic                      engine_empty_i,
    output logic                      cmpt_busy_o
);
    logic [`FLIP_DATASPIN-1:0]   mem [`FLIP_SPIN_DEPTH];
    logic [`FLIP_SPIN_PTR_W-1:0] wr_q;
    logic [`FLIP_SPIN_PTR_W-1:0] rd_q;
    logic [`FLIP_SPIN_PTR_W:0]   cnt_q;
    // Last spin pushed as a real improvement
    logic [`FLIP_DATASPIN-1:0]   anchor_q;
    cmpt_state_e                 state_q;
    cmpt_state_e                 state_d;
    logic                        alive_q;
    logic                        run_ok;
    logic                        pop_allowed;
    logic                        push_fire;
    logic                        pop_fire;

    assign run_ok = alive_q & en_i & ~flush_i;
    assign spin_push_ready_o = run_ok & (int'(cnt_q) != `FLIP_SPIN_DEPTH);
    assign push_fire = spin_push_valid_i & spin_push_ready_o;

    // Host may drain the FIFO only while idle
    assign pop_allowed = (state_q != IDLE) | host_readout_i;
    assign spin_pop_valid_o = run_ok & pop_allowed & (cnt_q != '0);
    assign spin_pop_o = mem[rd_q];
    assign pop_fire = spin_pop_valid_o & spin_pop_ready_i;

    assign cmpt_busy_o = (state_q != IDLE);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (cmpt_en_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (cmpt_stop_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Wait until nothing is left in flight
                if (cnt_q == '0 && engine_empty_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alive_q <= 1'b0;
            state_q <= IDLE;
            wr_q    <= '0;
            rd_q    <= '0;
            cnt_q   <= '0;
        end else begin
            alive_q <= 1'b1;
            if (en_i) begin
                state_q <= state_d;
                if (flush_i) begin
                    wr_q  <= '0;
                    rd_q  <= '0;
                    cnt_q <= '0;
                end else begin
                    if (push_fire) begin
                        wr_q <= wr_q + 1'b1;
                    end
                    if (pop_fire) begin
                        rd_q <= rd_q + 1'b1;
                    end
                    cnt_q <= cnt_q + {{`FLIP_SPIN_PTR_W{1'b0}}, push_fire}
                                   - {{`FLIP_SPIN_PTR_W{1'b0}}, pop_fire};
                end
            end
        end
    end

    // Push-none replays the anchor instead of the incoming data
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem[wr_q] <= spin_push_none_i ? anchor_q : spin_push_i;
            if (!spin_push_none_i) begin
                anchor_q <= spin_push_i;
            end
        end
    end

    // Pointers agree that a free entry exists for every push
    assert property (@(posedge clk_i) disable iff (reset_i)
        push_fire |-> ((wr_q != rd_q) || (cnt_q == '0)));

endmodule

`default_nettype wire

// ==== source/energy_fifo_maintainer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flip_defs.svh"

module energy_fifo_maintainer
    import energy_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      en_i,
    input  logic                      flush_i,
    input  logic                      cmpt_start_i,
    input  logic                      spin_valid_i,
    input  logic [`FLIP_DATASPIN-1:0] spin_i,
    output logic                      spin_ready_o,
    input  logic                      energy_valid_i,
    input  energy_t                   energy_i,
    output logic                      energy_ready_o,
    output logic                      spin_valid_o,
    output logic [`FLIP_DATASPIN-1:0] spin_o,
    output logic                      spin_push_none_o,
    input  logic                      spin_ready_i
);
    // Spins waiting for their energy
    logic [`FLIP_DATASPIN-1:0]   pend_mem [`FLIP_SPIN_DEPTH];
    logic [`FLIP_SPIN_PTR_W-1:0] pend_wr_q;
    logic [`FLIP_SPIN_PTR_W-1:0] pend_rd_q;
    logic [`FLIP_SPIN_PTR_W:0]   pend_cnt_q;
    logic                        alive_q;
    logic                        run_ok;
    // Lowest energy seen since the last start
    energy_t                     best_q;
    energy_cmp_e                 cmp_res;
    // Push that the spin FIFO has not taken yet
    logic                        push_pend_q;
    logic [`FLIP_DATASPIN-1:0]   push_spin_q;
    logic                        push_none_q;
    logic                        spin_fire;
    logic                        energy_fire;
    logic                        push_fire;

    assign run_ok = alive_q & en_i & ~flush_i;
    assign cmp_res = (energy_i < best_q) ? BETTER : NOT_BETTER;

    assign spin_ready_o = run_ok & (int'(pend_cnt_q) != `FLIP_SPIN_DEPTH);
    // No new energy while an earlier push is still waiting
    assign energy_ready_o = run_ok & ~push_pend_q & (pend_cnt_q != '0);
    assign spin_fire = spin_valid_i & spin_ready_o;
    assign energy_fire = energy_valid_i & energy_ready_o;

    // Fresh push comes straight from the pending head
    assign spin_valid_o = push_pend_q | energy_fire;
    assign spin_o = push_pend_q ? push_spin_q : pend_mem[pend_rd_q];
    assign spin_push_none_o = push_pend_q ? push_none_q : (cmp_res == NOT_BETTER);
    assign push_fire = spin_valid_o & spin_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alive_q     <= 1'b0;
            pend_wr_q   <= '0;
            pend_rd_q   <= '0;
            pend_cnt_q  <= '0;
            push_pend_q <= 1'b0;
            best_q      <= {1'b0, {(`FLIP_ENERGY_BIT-1){1'b1}}};
        end else begin
            alive_q <= 1'b1;
            if (en_i) begin
                // Start of a run forgets the old best
                if (cmpt_start_i) begin
                    best_q <= {1'b0, {(`FLIP_ENERGY_BIT-1){1'b1}}};
                end else if (energy_fire && cmp_res == BETTER) begin
                    best_q <= energy_i;
                end
                if (flush_i) begin
                    pend_wr_q   <= '0;
                    pend_rd_q   <= '0;
                    pend_cnt_q  <= '0;
                    push_pend_q <= 1'b0;
                end else begin
                    if (spin_fire) begin
                        pend_wr_q <= pend_wr_q + 1'b1;
                    end
                    if (energy_fire) begin
                        pend_rd_q <= pend_rd_q + 1'b1;
                    end
                    pend_cnt_q <= pend_cnt_q + {{`FLIP_SPIN_PTR_W{1'b0}}, spin_fire}
                                             - {{`FLIP_SPIN_PTR_W{1'b0}}, energy_fire};
                    // Park the push when the spin FIFO stalls
                    if (push_fire) begin
                        push_pend_q <= 1'b0;
                    end else if (energy_fire) begin
                        push_pend_q <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_fire) begin
            pend_mem[pend_wr_q] <= spin_i;
        end
        if (energy_fire) begin
            push_spin_q <= pend_mem[pend_rd_q];
            push_none_q <= (cmp_res == NOT_BETTER);
        end
    end

    // Pointers agree that a spin waits for every accepted energy
    assert property (@(posedge clk_i) disable iff (reset_i)
        energy_fire |-> ((pend_wr_q != pend_rd_q) || (int'(pend_cnt_q) == `FLIP_SPIN_DEPTH)));

endmodule

`default_nettype wire

// ==== source/energy_pkg.sv ====
`default_nettype none

`include "flip_defs.svh"

package energy_pkg;

    // Signed total energy from the evaluator
    typedef logic signed [`FLIP_ENERGY_BIT-1:0] energy_t;

    // Result of comparing a new energy against the best one
    typedef enum logic {
        NOT_BETTER,
        BETTER
    } energy_cmp_e;

endpackage

`default_nettype wire

// ==== source/spin_pkg.sv ====
`default_nettype none

package spin_pkg;

    // Computation state of the solver loop
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } cmpt_state_e;

    // Occupancy of one flip pipeline slot
    typedef enum logic [1:0] {
        EMPTY,
        READ,
        HOLD
    } flip_stage_e;

endpackage

`default_nettype wire

// ==== source/flip_defs.svh ====
`ifndef FLIP_DEFS_SVH
`define FLIP_DEFS_SVH

// Width of one spin vector
`define FLIP_DATASPIN 16

// Entries in the spin FIFO and in the pending FIFO
`define FLIP_SPIN_DEPTH 4

// Pointer width for both FIFOs
`define FLIP_SPIN_PTR_W 2

// Total energy width, signed
`define FLIP_ENERGY_BIT 16

// Number of flip icons in the external memory
`define FLIP_ICON_DEPTH 8

// Icon memory address width
`define FLIP_ICON_ADDR_W 3

`endif
